// File: dsi_packet_assembler.f
hw/dsi_proto_pkg.sv
hw/dsi_ctrl_pkg.sv
hw/dsi_packer.sv
hw/dsi_crc.sv
hw/dsi_ecc.sv
hw/dsi_tx_count.sv
hw/dsi_packet_fsm.sv
hw/dsi_packet_assembler.sv
dv/dsi_packet_assembler_tb.sv

// File: Bender.yml
package:
  name: dsi_packet_assembler

sources:
  # packages first, then the blocks, then the top level
  - files:
      - hw/dsi_proto_pkg.sv
      - hw/dsi_ctrl_pkg.sv
      - hw/dsi_packer.sv
      - hw/dsi_crc.sv
      - hw/dsi_ecc.sv
      - hw/dsi_tx_count.sv
      - hw/dsi_packet_fsm.sv
      - hw/dsi_packet_assembler.sv
  - target: test
    files:
      - dv/dsi_packet_assembler_tb.sv

// File: dv/dsi_packet_assembler_tb.sv
// ========================================
// table-driven test of the DSI packet layer
// short packets stand alone in a burst and
// run with the PHY always ready
// ========================================

module dsi_packet_assembler_tb
    import dsi_proto_pkg::*;
();

    localparam int          c_bpp       = 2;
    localparam int          c_drive_dly = 10;
    localparam int          c_timeout   = 3000;
    localparam int          c_num_pkts  = 11;
    localparam logic [31:0] c_seed      = 32'he90c_cb01;

    typedef struct packed {
        logic       islong;
        dsi_dtype_t dtype;
        dsi_word_t  word;   // word count or command
        logic       last;
        logic [7:0] seed;   // first payload byte
        logic       bp;     // random PHY back-pressure
    } pkt_t;

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   p_req_i;
    logic                   p_islong_i;
    dsi_dtype_t             p_type_i;
    dsi_word_t              p_wcount_i;
    dsi_word_t              p_command_i;
    logic                   p_last_i;
    logic [c_bpp*8-1:0]     p_payload_i;
    logic                   p_dreq_o;
    logic [7:0]             phy_d_o;
    logic                   phy_dvalid_o;
    logic                   phy_hs_request_o;
    logic                   phy_hs_dreq_i;

    pkt_t        table_q [c_num_pkts];
    logic [7:0]  exp_q [$];    // expected byte stream of one burst
    string       test_name;
    logic [31:0] rng_q;
    int          cur;
    int          last_idx;
    int          pulses;       // p_dreq_o pulses of the current packet
    int          pulse_total;
    int          rx_count;
    logic [7:0]  pay_byte;
    logic        dreq_seen;
    logic        start_pending;
    logic        bp_on;

    dsi_packet_assembler #(
        .g_bytes_per_pixel(c_bpp)
    ) dut0 (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .p_req_i(p_req_i), .p_islong_i(p_islong_i), .p_type_i(p_type_i),
        .p_wcount_i(p_wcount_i), .p_command_i(p_command_i), .p_last_i(p_last_i),
        .p_payload_i(p_payload_i), .p_dreq_o(p_dreq_o),
        .phy_d_o(phy_d_o), .phy_dvalid_o(phy_dvalid_o),
        .phy_hs_request_o(phy_hs_request_o), .phy_hs_dreq_i(phy_hs_dreq_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // DSI header parity equations, d[0] first on the wire
    function automatic logic [7:0] ecc_ref(dsi_header_t d);
        logic [7:0] p;
        p = 8'h00;
        p[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[13]
             ^ d[16] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
        p[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^ d[14]
             ^ d[17] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
        p[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^ d[15]
             ^ d[18] ^ d[20] ^ d[21] ^ d[22];
        p[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^ d[15]
             ^ d[19] ^ d[20] ^ d[21] ^ d[23];
        p[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^ d[18]
             ^ d[19] ^ d[20] ^ d[22] ^ d[23];
        p[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17]
             ^ d[18] ^ d[19] ^ d[21] ^ d[22] ^ d[23];
        return p;
    endfunction

    // one payload byte into the CRC, bit 0 first
    function automatic dsi_word_t crc_ref(dsi_word_t crc, logic [7:0] b);
        dsi_word_t c;
        logic      fb;
        c = crc;
        for (int k = 0; k < 8; k++) begin
            fb = c[0] ^ b[k];
            c  = c >> 1;
            if (fb) c = c ^ dsi_crc_poly;
        end
        return c;
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
            $display("Some tests failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic abort_run(string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "stopped on an error");
    endtask

    // expected bytes of one packet, appended to exp_q
    task automatic append_packet(int k);
        pkt_t        p;
        dsi_header_t hdr;
        dsi_word_t   crc;
        logic [7:0]  b;
        p   = table_q[k];
        hdr = {p.word[15:8], p.word[7:0], 2'b00, p.dtype};
        exp_q.push_back(hdr[7:0]);
        exp_q.push_back(hdr[15:8]);
        exp_q.push_back(hdr[23:16]);
        exp_q.push_back(ecc_ref(hdr));
        if (p.islong) begin
            crc = dsi_crc_init;
            for (int i = 0; i < int'(p.word); i++) begin
                b   = 8'(p.seed + i);
                crc = crc_ref(crc, b);
                exp_q.push_back(b);
            end
            exp_q.push_back(crc[7:0]);
            exp_q.push_back(crc[15:8]);
        end
    endtask

    // p_last_i is left alone, it changes on the packet's first pulse
    task automatic present_packet(int k);
        p_islong_i  = table_q[k].islong;
        p_type_i    = table_q[k].dtype;
        p_wcount_i  = table_q[k].islong ? table_q[k].word : 16'h0000;
        p_command_i = table_q[k].islong ? 16'h0000 : table_q[k].word;
        pulses      = 0;
        pay_byte    = table_q[k].seed;
    endtask

    // host and PHY models, a little after the rising edge
    task automatic drive_inputs();
        phy_hs_dreq_i = 1'b1;
        if (bp_on) begin
            rng_q         = xorshift32(rng_q);
            phy_hs_dreq_i = rng_q[0];
        end
        if (start_pending) begin
            start_pending = 1'b0;
            present_packet(cur);
            p_last_i = table_q[cur].last;
            p_req_i  = 1'b1;
        end
        if (dreq_seen) begin
            dreq_seen = 1'b0;
            p_last_i  = table_q[cur].last; // previous packet is past its CRC
            for (int i = 0; i < c_bpp; i++) begin
                p_payload_i[8*i +: 8] = pay_byte;
                pay_byte = pay_byte + 8'd1;
            end
            if (cur == last_idx) begin
                p_req_i = 1'b0; // header of the last packet is in
            end else if (pulses == int'(table_q[cur].word) / c_bpp) begin
                cur = cur + 1;
                present_packet(cur);
            end
        end
        if ((rx_count > 0) && !p_islong_i) p_req_i = 1'b0;
    endtask

    task automatic sample_outputs();
        if (phy_dvalid_o) begin
            if (rx_count >= exp_q.size()) begin
                abort_run($sformatf("%s: byte %0h on the PHY after the end of the stream",
                                    test_name, phy_d_o));
            end
            check_value($sformatf("%s byte %0d", test_name, rx_count),
                        exp_q[rx_count], phy_d_o);
            check_value($sformatf("%s hs request", test_name), 1, phy_hs_request_o);
            rx_count = rx_count + 1;
        end
        if (p_dreq_o) begin
            dreq_seen   = 1'b1;
            pulses      = pulses + 1;
            pulse_total = pulse_total + 1;
        end
    endtask

    task automatic run_cycle();
        @(posedge clk_i);
        #c_drive_dly;
        drive_inputs();
        @(negedge clk_i);
        sample_outputs();
    endtask

    task automatic run_burst(int first, int last);
        int cycles;
        int exp_pulses;
        exp_q.delete();
        exp_q.push_back(dsi_sync_byte);
        exp_pulses = 0;
        for (int k = first; k <= last; k++) begin
            append_packet(k);
            if (table_q[k].islong) exp_pulses += int'(table_q[k].word) / c_bpp;
        end
        test_name     = $sformatf("burst %0d..%0d", first, last);
        cur           = first;
        last_idx      = last;
        rx_count      = 0;
        pulse_total   = 0;
        dreq_seen     = 1'b0;
        bp_on         = table_q[first].bp;
        start_pending = 1'b1;
        cycles = 0;
        while (rx_count < exp_q.size()) begin
            if (cycles > c_timeout) abort_run({test_name, ": timeout on the byte stream"});
            run_cycle();
            cycles++;
        end
        cycles = 0;
        while (phy_hs_request_o) begin
            if (cycles > c_timeout) abort_run({test_name, ": hs request never fell"});
            run_cycle();
            cycles++;
        end
        repeat (8) run_cycle(); // nothing more may leave
        check_value({test_name, " dreq pulses"}, exp_pulses, pulse_total);
    endtask

    initial begin
        int first;
        rst_n_i       = 1'b0;
        p_req_i       = 1'b0;
        p_islong_i    = 1'b0;
        p_type_i      = '0;
        p_wcount_i    = '0;
        p_command_i   = '0;
        p_last_i      = 1'b0;
        p_payload_i   = '0;
        phy_hs_dreq_i = 1'b0;
        rng_q         = c_seed;
        cur           = 0;
        last_idx      = 0;
        pulses        = 0;
        pulse_total   = 0;
        rx_count      = 0;
        pay_byte      = 8'h00;
        dreq_seen     = 1'b0;
        start_pending = 1'b0;
        bp_on         = 1'b0;
        test_name     = "idle";

        //            islong  type   word      last  seed   bp
        table_q[0]  = '{1'b0, 6'h05, 16'h0011, 1'b1, 8'h00, 1'b0};
        table_q[1]  = '{1'b0, 6'h15, 16'h2C36, 1'b1, 8'h00, 1'b0};
        table_q[2]  = '{1'b1, 6'h39, 16'h0008, 1'b1, 8'h10, 1'b0};
        table_q[3]  = '{1'b1, 6'h29, 16'h0006, 1'b0, 8'h40, 1'b0};
        table_q[4]  = '{1'b1, 6'h39, 16'h000C, 1'b0, 8'h80, 1'b0};
        table_q[5]  = '{1'b1, 6'h3E, 16'h0004, 1'b1, 8'hF0, 1'b0};
        table_q[6]  = '{1'b1, 6'h29, 16'h0006, 1'b0, 8'h40, 1'b1}; // 3..5 again
        table_q[7]  = '{1'b1, 6'h39, 16'h000C, 1'b0, 8'h80, 1'b1};
        table_q[8]  = '{1'b1, 6'h3E, 16'h0004, 1'b1, 8'hF0, 1'b1};
        table_q[9]  = '{1'b1, 6'h39, 16'h0020, 1'b1, 8'hA5, 1'b1};
        table_q[10] = '{1'b1, 6'h29, 16'h0002, 1'b1, 8'h7E, 1'b1};

        repeat (5) @(posedge clk_i);
        #c_drive_dly;
        rst_n_i = 1'b1;

        repeat (20) begin
            run_cycle();
            check_value("idle p_dreq_o", 0, p_dreq_o);
            check_value("idle phy_dvalid_o", 0, phy_dvalid_o);
            check_value("idle phy_hs_request_o", 0, phy_hs_request_o);
        end

        first = 0;
        for (int k = 0; k < c_num_pkts; k++) begin
            if (table_q[k].last) begin
                run_burst(first, k);
                first = k + 1;
            end
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// File: hw/dsi_packet_assembler.sv
// ========================================
// DSI packet layer, one lane, VC 0
// ========================================

module dsi_packet_assembler
    import dsi_proto_pkg::*, dsi_ctrl_pkg::*;
#(
    parameter int g_bytes_per_pixel = 2 // 1 to 4
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    input  logic                           p_req_i,
    input  logic                           p_islong_i,
    input  dsi_dtype_t                     p_type_i,
    input  dsi_word_t                      p_wcount_i,
    input  dsi_word_t                      p_command_i,
    input  logic                           p_last_i,
    input  logic [g_bytes_per_pixel*8-1:0] p_payload_i,
    output logic                           p_dreq_o,

    output logic [7:0]                     phy_d_o,
    output logic                           phy_dvalid_o,
    output logic                           phy_hs_request_o,
    input  logic                           phy_hs_dreq_i
);

    logic [dsi_max_pack_bytes*8-1:0] pk_data;
    dsi_size_t                       pk_size;
    logic                            pk_valid;
    logic                            pk_req;
    logic                            pk_empty;
    logic                            pk_flush;
    dsi_count_t                      cnt;
    dsi_count_t                      cnt_value;
    logic                            cnt_load;
    logic                            cnt_dec;
    dsi_word_t                       crc;
    logic                            crc_clear;
    logic                            crc_valid;
    dsi_header_t                     hdr;
    logic [7:0]                      ecc;

    dsi_packet_fsm #(
        .g_bytes_per_pixel(g_bytes_per_pixel)
    ) u_fsm (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .p_req_i(p_req_i), .p_islong_i(p_islong_i), .p_type_i(p_type_i),
        .p_wcount_i(p_wcount_i), .p_command_i(p_command_i), .p_last_i(p_last_i),
        .p_payload_i(p_payload_i), .p_dreq_o(p_dreq_o),
        .phy_hs_dreq_i(phy_hs_dreq_i), .phy_hs_request_o(phy_hs_request_o),
        .pk_req_i(pk_req), .pk_empty_i(pk_empty), .pk_data_o(pk_data),
        .pk_size_o(pk_size), .pk_valid_o(pk_valid), .pk_flush_o(pk_flush),
        .cnt_i(cnt), .cnt_load_o(cnt_load), .cnt_value_o(cnt_value), .cnt_dec_o(cnt_dec),
        .crc_i(crc), .crc_clear_o(crc_clear), .crc_valid_o(crc_valid),
        .hdr_o(hdr), .ecc_i(ecc)
    );

    dsi_tx_count #(
        .g_bytes_per_pixel(g_bytes_per_pixel)
    ) u_count (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .load_i(cnt_load), .load_value_i(cnt_value), .dec_i(cnt_dec), .count_o(cnt)
    );

    dsi_packer u_packer (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .d_i(pk_data), .d_size_i(pk_size), .d_valid_i(pk_valid), .d_req_o(pk_req),
        .empty_o(pk_empty), .flush_i(pk_flush),
        .q_req_i(phy_hs_dreq_i), .q_o(phy_d_o), .q_valid_o(phy_dvalid_o)
    );

    dsi_crc #(
        .g_bytes_per_pixel(g_bytes_per_pixel)
    ) u_crc (
        .clk_i(clk_i), .clear_i(crc_clear), .valid_i(crc_valid),
        .d_i(p_payload_i), .crc_o(crc)
    );

    dsi_ecc u_ecc (
        .hdr_i(hdr),
        .ecc_o(ecc)
    );

endmodule

// File: hw/dsi_packet_fsm.sv
// ========================================
// packet FSM: sync, header, payload, CRC
// host holds p_req_i until after the last
// ========================================

module dsi_packet_fsm
    import dsi_proto_pkg::*, dsi_ctrl_pkg::*;
#(
    parameter int g_bytes_per_pixel = 2
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    input  logic                            p_req_i,
    input  logic                            p_islong_i,
    input  dsi_dtype_t                      p_type_i,
    input  dsi_word_t                       p_wcount_i,
    input  dsi_word_t                       p_command_i,
    input  logic                            p_last_i,
    input  logic [g_bytes_per_pixel*8-1:0]  p_payload_i,
    output logic                            p_dreq_o,

    input  logic                            phy_hs_dreq_i,
    output logic                            phy_hs_request_o,

    input  logic                            pk_req_i,
    input  logic                            pk_empty_i,
    output logic [dsi_max_pack_bytes*8-1:0] pk_data_o,
    output dsi_size_t                       pk_size_o,
    output logic                            pk_valid_o,
    output logic                            pk_flush_o,

    input  dsi_count_t                      cnt_i,
    output logic                            cnt_load_o,
    output dsi_count_t                      cnt_value_o,
    output logic                            cnt_dec_o,

    input  dsi_word_t                       crc_i,
    output logic                            crc_clear_o,
    output logic                            crc_valid_o,

    output dsi_header_t                     hdr_o,
    input  logic [7:0]                      ecc_i
);

    localparam dsi_count_t c_bpp       = dsi_count_t'(g_bytes_per_pixel);
    localparam dsi_count_t c_hdr_bytes = dsi_count_t'(4);

    dsi_state_e state_q;
    logic       req_q;   // packer had room last cycle
    logic       dreq_q;  // host word arrives this cycle
    logic       done_q;  // burst ended by a last packet
    logic       hdr_end;
    dsi_word_t  word;

    assign word    = p_islong_i ? p_wcount_i : p_command_i;
    assign hdr_o   = {word[15:8], word[7:0], 2'b00, p_type_i}; // VC = 0
    assign hdr_end = (state_q == st_header) && (cnt_i <= c_bpp);

    always_comb begin
        pk_data_o  = '0;
        pk_size_o  = 3'd1;
        pk_valid_o = 1'b0;
        case (state_q)
            st_lp: begin
                pk_data_o[7:0] = dsi_sync_byte;
                pk_valid_o     = req_q && p_req_i && phy_hs_dreq_i;
            end
            st_idle: begin
                pk_data_o  = {ecc_i, hdr_o};
                pk_size_o  = 3'd4;
                pk_valid_o = req_q && p_req_i;
            end
            st_payload: begin
                pk_data_o[g_bytes_per_pixel*8-1:0] = p_payload_i;
                pk_size_o  = dsi_size_t'(g_bytes_per_pixel);
                pk_valid_o = dreq_q; // answer to last cycle's pulse
            end
            st_crc: begin
                pk_data_o[15:0] = crc_i; // low byte first
                pk_size_o       = 3'd2;
                pk_valid_o      = req_q;
            end
            default: ;
        endcase
    end

    // a pulse reserves one pixel of count
    assign p_dreq_o  = (state_q == st_payload) && pk_req_i && (cnt_i != '0);
    assign cnt_dec_o = p_dreq_o || ((state_q == st_header) && !hdr_end);

    assign cnt_load_o  = ((state_q == st_idle) && pk_valid_o) || (hdr_end && p_islong_i);
    assign cnt_value_o = (state_q == st_idle) ? c_hdr_bytes : p_wcount_i;

    assign crc_clear_o = (state_q == st_idle);
    assign crc_valid_o = (state_q == st_payload) && dreq_q;

    assign pk_flush_o       = (state_q == st_lp) && (!p_req_i || done_q);
    assign phy_hs_request_o = p_req_i || (state_q != st_lp) || !pk_empty_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= st_lp;
            req_q   <= 1'b0;
            dreq_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            req_q  <= pk_req_i;
            dreq_q <= p_dreq_o;
            if (!p_req_i) begin
                done_q <= 1'b0;
            end
            case (state_q)
                st_lp: begin
                    if (pk_valid_o) state_q <= st_idle;
                end
                st_idle: begin
                    if (pk_valid_o) begin
                        state_q <= st_header;
                    end else if (!p_req_i) begin
                        state_q <= st_lp;
                    end
                end
                st_header: begin
                    if (hdr_end) begin
                        if (p_islong_i) begin
                            state_q <= st_payload;
                        end else if (p_last_i) begin
                            state_q <= st_lp;
                            done_q  <= 1'b1;
                        end else begin
                            state_q <= st_idle;
                        end
                    end
                end
                st_payload: begin
                    if ((cnt_i == '0) && !dreq_q) state_q <= st_crc;
                end
                st_crc: begin
                    if (pk_valid_o) begin
                        state_q <= p_last_i ? st_lp : st_idle;
                        done_q  <= p_last_i;
                    end
                end
                default: state_q <= st_lp;
            endcase
        end
    end

    // payload is only pulled while a long packet is described
    a_dreq_long : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        p_dreq_o |-> p_islong_i
    );

endmodule

// File: hw/dsi_tx_count.sv
// ========================================
// byte down counter, steps of one pixel
// word counts must be a pixel multiple
// ========================================

module dsi_tx_count
    import dsi_ctrl_pkg::*;
#(
    parameter int g_bytes_per_pixel = 2
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       load_i,
    input  dsi_count_t load_value_i,
    input  logic       dec_i,
    output dsi_count_t count_o
);

    localparam dsi_count_t c_step = dsi_count_t'(g_bytes_per_pixel);

    dsi_count_t count_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= load_value_i; // load wins over dec
        end else if (dec_i) begin
            count_q <= count_q - c_step;
        end
    end

    assign count_o = count_q;

    // a bad word count from the host shows up here
    a_no_wrap : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (dec_i && !load_i) |-> (count_q >= c_step)
    );

endmodule

// File: hw/dsi_ecc.sv
// ========================================
// header ECC, combinational
// hdr_i bit 0 is the first bit on the wire
// ========================================

module dsi_ecc
    import dsi_proto_pkg::*;
(
    input  dsi_header_t hdr_i,
    output logic [7:0]  ecc_o
);

    // header bits covered by each parity bit
    localparam dsi_header_t c_mask_p0 = 24'hF12CB7;
    localparam dsi_header_t c_mask_p1 = 24'hF2555B;
    localparam dsi_header_t c_mask_p2 = 24'h749A6D;
    localparam dsi_header_t c_mask_p3 = 24'hB8E38E;
    localparam dsi_header_t c_mask_p4 = 24'hDF03F0;
    localparam dsi_header_t c_mask_p5 = 24'hEFFC00;

    always_comb begin
        ecc_o[0] = ^(hdr_i & c_mask_p0);
        ecc_o[1] = ^(hdr_i & c_mask_p1);
        ecc_o[2] = ^(hdr_i & c_mask_p2);
        ecc_o[3] = ^(hdr_i & c_mask_p3);
        ecc_o[4] = ^(hdr_i & c_mask_p4);
        ecc_o[5] = ^(hdr_i & c_mask_p5);
        ecc_o[7:6] = 2'b00; // unused in DSI
    end

endmodule

// File: hw/dsi_crc.sv
// ========================================
// payload CRC-16, all bytes of d_i per strobe
// seed applied by clear_i, no final xor
// ========================================

module dsi_crc
    import dsi_proto_pkg::*;
#(
    parameter int g_bytes_per_pixel = 2
) (
    input  logic                           clk_i,
    input  logic                           clear_i,
    input  logic                           valid_i,
    input  logic [g_bytes_per_pixel*8-1:0] d_i,     // first byte in the low bits
    output dsi_word_t                      crc_o
);

    dsi_word_t crc_q;
    dsi_word_t crc_next;

    // one byte, LSB first
    function automatic dsi_word_t crc_byte(dsi_word_t crc, logic [7:0] b);
        dsi_word_t c;
        c = crc;
        for (int k = 0; k < 8; k++) begin
            if (c[0] ^ b[k]) begin
                c = (c >> 1) ^ dsi_crc_poly;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_comb begin
        crc_next = crc_q;
        for (int i = 0; i < g_bytes_per_pixel; i++) begin
            crc_next = crc_byte(crc_next, d_i[8*i +: 8]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (clear_i) begin
            crc_q <= dsi_crc_init;
        end else if (valid_i) begin
            crc_q <= crc_next;
        end
    end

    assign crc_o = crc_q;

endmodule

// File: hw/dsi_packer.sv
// ========================================
// 8-byte store, one byte out per ready cycle
// a load may arrive one cycle after d_req_o
// flush_i holds d_req_o low while draining
// ========================================

module dsi_packer
    import dsi_proto_pkg::*, dsi_ctrl_pkg::*;
(
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    input  logic [dsi_max_pack_bytes*8-1:0] d_i,       // first byte in the low bits
    input  dsi_size_t                       d_size_i,
    input  logic                            d_valid_i,
    output logic                            d_req_o,
    output logic                            empty_o,
    input  logic                            flush_i,

    input  logic                            q_req_i,   // PHY ready level
    output logic [7:0]                      q_o,
    output logic                            q_valid_o
);

    localparam int c_depth = 2 * dsi_max_pack_bytes;
    localparam int c_lvl_w = $clog2(c_depth + 1);

    logic [c_depth-1:0][7:0] store_q;
    logic [c_depth-1:0][7:0] store_next;
    logic [c_lvl_w-1:0]      level_q;
    logic [c_lvl_w-1:0]      level_next;
    logic [c_lvl_w-1:0]      base;       // write position after this cycle's shift
    logic                    pop;
    logic                    q_valid_q;

    assign pop = q_req_i && (level_q != '0);

    assign level_next = level_q
                      + c_lvl_w'(d_valid_i ? d_size_i : 3'd0)
                      - c_lvl_w'(pop);

    // room for a full load one cycle from now
    assign d_req_o = !flush_i && (level_next <= c_lvl_w'(c_depth - dsi_max_pack_bytes));

    always_comb begin
        base = level_q - c_lvl_w'(pop);
        store_next = store_q;
        if (pop) begin
            store_next = {8'h00, store_q[c_depth-1:1]}; // byte 0 leaves
        end
        if (d_valid_i) begin
            for (int i = 0; i < dsi_max_pack_bytes; i++) begin
                if ((i < d_size_i) && (base + i < c_depth)) begin
                    store_next[base + i] = d_i[8*i +: 8];
                end
            end
        end
    end

    // data bytes, no reset needed
    always_ff @(posedge clk_i) begin
        store_q <= store_next;
        if (pop) begin
            q_o <= store_q[0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            level_q   <= '0;
            q_valid_q <= 1'b0;
        end else begin
            level_q   <= level_next;
            q_valid_q <= pop;
        end
    end

    assign q_valid_o = q_valid_q;

    // byte still on q_o counts as not empty
    assign empty_o = (level_q == '0) && !q_valid_q;

    // the FSM's late load must always fit
    a_no_overflow : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        d_valid_i |-> (level_next <= c_lvl_w'(c_depth))
    );

endmodule

// File: hw/dsi_ctrl_pkg.sv
// ========================================
// packet FSM encoding and counter widths
// ========================================

package dsi_ctrl_pkg;

    // packet state machine
    typedef enum logic [2:0] {
        st_lp      = 3'd0, // low power, waits to send the sync byte
        st_idle    = 3'd1, // loads header and ECC
        st_header  = 3'd2,
        st_payload = 3'd3,
        st_crc     = 3'd4
    } dsi_state_e;

    // bytes still to be loaded, wide enough for any word count
    typedef logic [15:0] dsi_count_t;

    // bytes in one packer load, 1 to 4
    typedef logic [2:0] dsi_size_t;

endpackage

// File: hw/dsi_proto_pkg.sv
// ========================================
// DSI packet-layer protocol constants
// virtual channel bits are always zero
// ========================================

package dsi_proto_pkg;

    // burst start byte sent once per HS burst
    localparam logic [7:0] dsi_sync_byte = 8'hB8;

    // 6-bit data type field of the data identifier
    typedef logic [5:0] dsi_dtype_t;

    // word count of a long packet, or command data of a short one
    typedef logic [15:0] dsi_word_t;

    // header as sent on the wire, first byte in the low bits
    //  [7:0]   data identifier
    //  [15:8]  word/command low byte
    //  [23:16] word/command high byte
    typedef logic [23:0] dsi_header_t;

    // payload CRC, reflected CCITT with all-ones seed
    localparam dsi_word_t dsi_crc_init = 16'hFFFF;
    localparam dsi_word_t dsi_crc_poly = 16'h8408; // x^16 + x^12 + x^5 + 1, reflected

    // widest single load into the byte packer
    localparam int dsi_max_pack_bytes = 4;

endpackage
